/* verilog/fix_rx_defines.svh */
// widths, FIX tag codes and message-type characters, included by every fix_rx source file
`ifndef FIX_RX_DEFINES_SVH
`define FIX_RX_DEFINES_SVH

// beat and sequence widths
`define FIX_VAL_W 64
`define FIX_TAG_W 32
`define FIX_SEQ_W 27

// "4.4" in the low three bytes of the begin-string value
`define FIX_MAX_VERSION 24'h34_2e_34

// tag numbers as right-justified ASCII
`define FIX_TAG_BEGIN    32'h0000_0038
`define FIX_TAG_BODYLEN  32'h0000_0039
`define FIX_TAG_MSGTYPE  32'h0000_3335
`define FIX_TAG_SEQNUM   32'h0000_3334
`define FIX_TAG_POSSDUP  32'h0000_3433
`define FIX_TAG_SENDER   32'h0000_3439
`define FIX_TAG_SENDTIME 32'h0000_3532
`define FIX_TAG_TARGET   32'h0000_3536
`define FIX_TAG_GAPFILL  32'h0031_3233
`define FIX_TAG_CHECKSUM 32'h0000_3130

// single-character message types
`define FIX_MT_LOGON     8'h41
`define FIX_MT_LOGOUT    8'h35
`define FIX_MT_HEARTBEAT 8'h30
`define FIX_MT_RESEND    8'h32
`define FIX_MT_SEQRESET  8'h34
`define FIX_MT_ORDER     8'h44

// boolean flag value "Y"
`define FIX_YES 8'h59

`endif

/* verilog/fix_rx_pkg.sv */
// shared types of the fix_rx checker, referenced by scoped name from the RTL and testbench
`include "fix_rx_defines.svh"

package fix_rx_pkg;

	typedef logic [`FIX_TAG_W-1:0] tag_t;
	typedef logic [`FIX_VAL_W-1:0] val_t;
	typedef logic [`FIX_SEQ_W-1:0] seq_t;

	// verdict codes, same numbering as the session layer
	typedef enum logic [2:0] {
		ERR_NONE         = 3'd0,
		ERR_SEQ_HIGH     = 3'd1,
		ERR_GARBLED      = 3'd2,
		ERR_BAD_VERSION  = 3'd3,
		ERR_SEQ_LOW      = 3'd4,
		ERR_BAD_MSG_TYPE = 3'd6,
		ERR_TAG_MISSING  = 3'd7
	} fix_err_e;

	typedef enum logic [2:0] {
		CLS_NONE      = 3'd0,
		CLS_LOGON     = 3'd1,
		CLS_HEARTBEAT = 3'd2,
		CLS_RESEND    = 3'd3,
		CLS_LOGOUT    = 3'd4,
		CLS_SEQ_RESET = 3'd5,
		CLS_GAP_FILL  = 3'd6,
		CLS_BUSINESS  = 3'd7
	} fix_class_e;

	typedef enum logic [2:0] {
		HS_BEGIN_TAG, HS_VERSION, HS_BODYLEN_TAG, HS_BODYLEN_VAL, HS_TYPE_TAG, HS_TYPE_VAL, HS_BODY
	} hdr_state_e;

endpackage

/* verilog/fix_header_checker.sv */
// header FSM of fix_rx that checks tag order 8/9/35, the version and the type for fix_rx_top
`timescale 1ns/10ps
`include "fix_rx_defines.svh"

module fix_header_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   tag_valid_i,
	input  logic                   start_of_message_i,
	input  logic                   end_of_message_i,
	input  fix_rx_pkg::tag_t       tag_i,
	input  logic                   val_valid_i,
	input  fix_rx_pkg::val_t       val_i,
	output logic                   hdr_err_valid_o,
	output fix_rx_pkg::fix_err_e   hdr_err_o,
	output logic                   body_active_o,
	output fix_rx_pkg::fix_class_e hdr_class_o
);

	fix_rx_pkg::hdr_state_e state_q;
	fix_rx_pkg::hdr_state_e state_d;
	fix_rx_pkg::fix_class_e type_class;
	fix_rx_pkg::fix_err_e   err_code;
	logic                   err_fire;

	// only single-character types with empty upper bytes are known
	function automatic fix_rx_pkg::fix_class_e decode_type(input fix_rx_pkg::val_t v);
		fix_rx_pkg::fix_class_e cls;
		cls = fix_rx_pkg::CLS_NONE;
		if (v[`FIX_VAL_W-1:8] == '0) begin
			case (v[7:0])
				`FIX_MT_LOGON:     cls = fix_rx_pkg::CLS_LOGON;
				`FIX_MT_LOGOUT:    cls = fix_rx_pkg::CLS_LOGOUT;
				`FIX_MT_HEARTBEAT: cls = fix_rx_pkg::CLS_HEARTBEAT;
				`FIX_MT_RESEND:    cls = fix_rx_pkg::CLS_RESEND;
				// gap fill is only known once tag 123 is seen
				`FIX_MT_SEQRESET:  cls = fix_rx_pkg::CLS_SEQ_RESET;
				`FIX_MT_ORDER:     cls = fix_rx_pkg::CLS_BUSINESS;
				default:           cls = fix_rx_pkg::CLS_NONE;
			endcase
		end
		return cls;
	endfunction

	assign type_class = decode_type(val_i);
	assign body_active_o = (state_q == fix_rx_pkg::HS_BODY);

	always_comb begin
		state_d = state_q;
		err_fire = 1'b0;
		err_code = fix_rx_pkg::ERR_GARBLED;
		case (state_q)
			// only a start beat leaves idle
			fix_rx_pkg::HS_BEGIN_TAG: begin
				if (tag_valid_i && start_of_message_i) begin
					if (tag_i == `FIX_TAG_BEGIN)
						state_d = fix_rx_pkg::HS_VERSION;
					else
						err_fire = 1'b1;
				end
			end
			fix_rx_pkg::HS_VERSION: begin
				if (val_valid_i && val_i[23:0] > `FIX_MAX_VERSION) begin
					err_fire = 1'b1;
					err_code = fix_rx_pkg::ERR_BAD_VERSION;
				end else if (val_valid_i) begin
					state_d = fix_rx_pkg::HS_BODYLEN_TAG;
				end else if (tag_valid_i) begin
					err_fire = 1'b1;
				end
			end
			fix_rx_pkg::HS_BODYLEN_TAG: begin
				if (tag_valid_i && tag_i == `FIX_TAG_BODYLEN)
					state_d = fix_rx_pkg::HS_BODYLEN_VAL;
				else if (tag_valid_i)
					err_fire = 1'b1;
			end
			// body length value accepted as is
			fix_rx_pkg::HS_BODYLEN_VAL: begin
				if (val_valid_i)
					state_d = fix_rx_pkg::HS_TYPE_TAG;
				else if (tag_valid_i)
					err_fire = 1'b1;
			end
			fix_rx_pkg::HS_TYPE_TAG: begin
				if (tag_valid_i && tag_i == `FIX_TAG_MSGTYPE)
					state_d = fix_rx_pkg::HS_TYPE_VAL;
				else if (tag_valid_i)
					err_fire = 1'b1;
			end
			fix_rx_pkg::HS_TYPE_VAL: begin
				if (val_valid_i && type_class != fix_rx_pkg::CLS_NONE) begin
					state_d = fix_rx_pkg::HS_BODY;
				end else if (val_valid_i) begin
					err_fire = 1'b1;
					err_code = fix_rx_pkg::ERR_BAD_MSG_TYPE;
				end else if (tag_valid_i) begin
					err_fire = 1'b1;
				end
			end
			fix_rx_pkg::HS_BODY: begin
				if (tag_valid_i && end_of_message_i)
					state_d = fix_rx_pkg::HS_BEGIN_TAG;
			end
			default: state_d = fix_rx_pkg::HS_BEGIN_TAG;
		endcase
		// every error drops back to idle
		if (err_fire)
			state_d = fix_rx_pkg::HS_BEGIN_TAG;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= fix_rx_pkg::HS_BEGIN_TAG;
			hdr_err_valid_o <= 1'b0;
		end else begin
			state_q <= state_d;
			hdr_err_valid_o <= err_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (err_fire)
			hdr_err_o <= err_code;
		// class holds through the body for the classifier
		if (state_q == fix_rx_pkg::HS_TYPE_VAL && state_d == fix_rx_pkg::HS_BODY)
			hdr_class_o <= type_class;
	end

	// tag and value beats never share a cycle
	a_beats_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(tag_valid_i && val_valid_i))
		else $error("tag beat and value beat in the same cycle");

endmodule

/* verilog/fix_field_capture.sv */
// body branch of fix_rx, captures session fields and converts the ASCII sequence number
`timescale 1ns/10ps
`include "fix_rx_defines.svh"

module fix_field_capture (
	input  logic             clk,
	input  logic             rst,
	input  logic             tag_valid_i,
	input  logic             val_valid_i,
	input  logic             start_of_message_i,
	input  logic             end_of_message_i,
	input  logic             body_active_i,
	input  logic             checksum_ok_i,
	input  fix_rx_pkg::tag_t tag_i,
	input  fix_rx_pkg::val_t val_i,
	input  fix_rx_pkg::seq_t expected_seq_i,
	output logic             fields_done_o,
	output logic             seq_bad_o,
	output logic             has_seq_o,
	output logic             has_sender_o,
	output logic             has_target_o,
	output logic             has_sendtime_o,
	output logic             poss_dup_o,
	output logic             gap_fill_o,
	output logic             checksum_ok_o,
	output fix_rx_pkg::seq_t seq_num_o,
	output fix_rx_pkg::seq_t expected_seq_o
);

	fix_rx_pkg::tag_t     last_tag;
	logic [`FIX_SEQ_W:0]  seq_conv;
	logic                 val_is_yes;

	// msb is the bad flag, a zero byte after a digit counts as bad
	function automatic logic [`FIX_SEQ_W:0] ascii_to_seq(input fix_rx_pkg::val_t v);
		fix_rx_pkg::seq_t acc;
		logic             bad;
		logic             seen;
		logic [7:0]       ch;
		acc = '0;
		bad = 1'b0;
		seen = 1'b0;
		for (int i = 7; i >= 0; i--) begin
			ch = v[i*8 +: 8];
			if (ch >= 8'h30 && ch <= 8'h39) begin
				seen = 1'b1;
				acc = acc * fix_rx_pkg::seq_t'(10) + {{(`FIX_SEQ_W-8){1'b0}}, ch - 8'h30};
			end else if (ch != 8'h00 || seen) begin
				bad = 1'b1;
			end
		end
		return {bad, acc};
	endfunction

	assign seq_conv = ascii_to_seq(val_i);
	assign val_is_yes = (val_i == {{(`FIX_VAL_W-8){1'b0}}, `FIX_YES});

	// tag of the pending value, end beat has no value after it
	always_ff @(posedge clk) begin
		if (body_active_i && tag_valid_i && !end_of_message_i)
			last_tag <= tag_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fields_done_o <= 1'b0;
			{seq_bad_o, has_seq_o, has_sender_o, has_target_o} <= '0;
			{has_sendtime_o, poss_dup_o, gap_fill_o} <= '0;
		end else begin
			fields_done_o <= body_active_i && tag_valid_i && end_of_message_i;
			if (start_of_message_i) begin
				{seq_bad_o, has_seq_o, has_sender_o, has_target_o} <= '0;
				{has_sendtime_o, poss_dup_o, gap_fill_o} <= '0;
			end else if (body_active_i && val_valid_i) begin
				case (last_tag)
					`FIX_TAG_SEQNUM: begin
						has_seq_o <= 1'b1;
						seq_bad_o <= seq_conv[`FIX_SEQ_W];
					end
					`FIX_TAG_SENDER:   has_sender_o <= 1'b1;
					`FIX_TAG_TARGET:   has_target_o <= 1'b1;
					`FIX_TAG_SENDTIME: has_sendtime_o <= 1'b1;
					`FIX_TAG_POSSDUP:  poss_dup_o <= val_is_yes;
					`FIX_TAG_GAPFILL:  gap_fill_o <= val_is_yes;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_of_message_i)
			seq_num_o <= '0;
		else if (body_active_i && val_valid_i && last_tag == `FIX_TAG_SEQNUM)
			seq_num_o <= seq_conv[`FIX_SEQ_W-1:0];
		// session inputs are only valid on the end beat
		if (body_active_i && tag_valid_i && end_of_message_i) begin
			checksum_ok_o <= checksum_ok_i;
			expected_seq_o <= expected_seq_i;
		end
	end

	// messages are at least 7 beats apart
	a_done_single: assert property (@(posedge clk) disable iff (rst)
		fields_done_o |=> !fields_done_o)
		else $error("fields_done on consecutive cycles");

endmodule

/* verilog/fix_msg_classifier.sv */
// verdict stage of fix_rx, merges header errors and captured fields into one result per message
`timescale 1ns/10ps

module fix_msg_classifier (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hdr_err_valid_i,
	input  fix_rx_pkg::fix_err_e   hdr_err_i,
	input  fix_rx_pkg::fix_class_e hdr_class_i,
	input  logic                   fields_done_i,
	input  logic                   seq_bad_i,
	input  logic                   has_seq_i,
	input  logic                   has_sender_i,
	input  logic                   has_target_i,
	input  logic                   has_sendtime_i,
	input  logic                   poss_dup_i,
	input  logic                   gap_fill_i,
	input  logic                   checksum_ok_i,
	input  fix_rx_pkg::seq_t       seq_num_i,
	input  fix_rx_pkg::seq_t       expected_seq_i,
	output logic                   result_valid_o,
	output fix_rx_pkg::fix_err_e   error_o,
	output fix_rx_pkg::fix_class_e msg_class_o,
	output fix_rx_pkg::seq_t       seq_num_o
);

	logic                   is_reset;
	logic                   tags_ok;
	logic                   low_excused;
	fix_rx_pkg::fix_err_e   field_err;
	fix_rx_pkg::fix_class_e field_class;

	assign is_reset = (hdr_class_i == fix_rx_pkg::CLS_SEQ_RESET);
	assign tags_ok = has_seq_i && has_sender_i && has_target_i && has_sendtime_i;
	// a plain reset may move the sequence backwards
	assign low_excused = poss_dup_i || (is_reset && !gap_fill_i);

	always_comb begin
		if (!checksum_ok_i || seq_bad_i)
			field_err = fix_rx_pkg::ERR_GARBLED;
		else if (!tags_ok)
			field_err = fix_rx_pkg::ERR_TAG_MISSING;
		else if (seq_num_i < expected_seq_i && !low_excused)
			field_err = fix_rx_pkg::ERR_SEQ_LOW;
		else if (seq_num_i > expected_seq_i)
			field_err = fix_rx_pkg::ERR_SEQ_HIGH;
		else
			field_err = fix_rx_pkg::ERR_NONE;
	end

	assign field_class = (is_reset && gap_fill_i) ? fix_rx_pkg::CLS_GAP_FILL : hdr_class_i;

	always_ff @(posedge clk) begin
		if (rst)
			result_valid_o <= 1'b0;
		else
			result_valid_o <= hdr_err_valid_i || fields_done_i;
	end

	// header errors carry no class and no sequence
	always_ff @(posedge clk) begin
		if (hdr_err_valid_i) begin
			error_o <= hdr_err_i;
			msg_class_o <= fix_rx_pkg::CLS_NONE;
			seq_num_o <= '0;
		end else if (fields_done_i) begin
			error_o <= field_err;
			msg_class_o <= field_class;
			seq_num_o <= seq_num_i;
		end
	end

	// one verdict per message, never back to back
	a_result_single: assert property (@(posedge clk) disable iff (rst)
		result_valid_o |=> !result_valid_o)
		else $error("result_valid on consecutive cycles");

endmodule

/* verilog/fix_rx_top.sv */
// top level of the fix_rx receive checker, wires the header FSM, field capture and classifier
`timescale 1ns/10ps

module fix_rx_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   tag_valid_i,
	input  fix_rx_pkg::tag_t       tag_i,
	input  logic                   val_valid_i,
	input  fix_rx_pkg::val_t       val_i,
	input  logic                   start_of_message_i,
	input  logic                   end_of_message_i,
	input  logic                   checksum_ok_i,
	input  fix_rx_pkg::seq_t       expected_seq_i,
	output logic                   result_valid_o,
	output fix_rx_pkg::fix_err_e   error_o,
	output fix_rx_pkg::fix_class_e msg_class_o,
	output fix_rx_pkg::seq_t       seq_num_o
);

	logic                   hdr_err_valid;
	fix_rx_pkg::fix_err_e   hdr_err;
	fix_rx_pkg::fix_class_e hdr_class;
	logic                   body_active;
	logic                   fields_done;
	logic                   seq_bad;
	logic                   has_seq;
	logic                   has_sender;
	logic                   has_target;
	logic                   has_sendtime;
	logic                   poss_dup;
	logic                   gap_fill;
	logic                   checksum_ok;
	fix_rx_pkg::seq_t       seq_num;
	fix_rx_pkg::seq_t       expected_seq;

	fix_header_checker u_hdr (
		.clk(clk), .rst(rst),
		.tag_valid_i(tag_valid_i), .start_of_message_i(start_of_message_i),
		.end_of_message_i(end_of_message_i), .tag_i(tag_i),
		.val_valid_i(val_valid_i), .val_i(val_i),
		.hdr_err_valid_o(hdr_err_valid), .hdr_err_o(hdr_err),
		.body_active_o(body_active), .hdr_class_o(hdr_class)
	);

	// runs alongside the header FSM, gated by body_active
	fix_field_capture u_cap (
		.clk(clk), .rst(rst),
		.tag_valid_i(tag_valid_i), .val_valid_i(val_valid_i),
		.start_of_message_i(start_of_message_i), .end_of_message_i(end_of_message_i),
		.body_active_i(body_active), .checksum_ok_i(checksum_ok_i),
		.tag_i(tag_i), .val_i(val_i), .expected_seq_i(expected_seq_i),
		.fields_done_o(fields_done), .seq_bad_o(seq_bad), .has_seq_o(has_seq),
		.has_sender_o(has_sender), .has_target_o(has_target), .has_sendtime_o(has_sendtime),
		.poss_dup_o(poss_dup), .gap_fill_o(gap_fill), .checksum_ok_o(checksum_ok),
		.seq_num_o(seq_num), .expected_seq_o(expected_seq)
	);

	fix_msg_classifier u_cls (
		.clk(clk), .rst(rst),
		.hdr_err_valid_i(hdr_err_valid), .hdr_err_i(hdr_err), .hdr_class_i(hdr_class),
		.fields_done_i(fields_done), .seq_bad_i(seq_bad), .has_seq_i(has_seq),
		.has_sender_i(has_sender), .has_target_i(has_target), .has_sendtime_i(has_sendtime),
		.poss_dup_i(poss_dup), .gap_fill_i(gap_fill), .checksum_ok_i(checksum_ok),
		.seq_num_i(seq_num), .expected_seq_i(expected_seq),
		.result_valid_o(result_valid_o), .error_o(error_o),
		.msg_class_o(msg_class_o), .seq_num_o(seq_num_o)
	);

endmodule

/* dv/tb_clk_gen.sv */
// clock and reset source of the fix_rx testbench, 8 ns period and reset for 8 cycles
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// reset drops on the 8th rising edge
	initial begin
		rst_o <= 1'b1;
		repeat (8) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

/* dv/fix_rx_tb.sv */
// directed and random tests of fix_rx_top, each verdict is checked against a reference model
`timescale 1ns/10ps
`include "fix_rx_defines.svh"

module fix_rx_tb;

	localparam int MAX_CYCLES = 3000;

	typedef struct packed {
		int                     due;
		fix_rx_pkg::fix_err_e   err;
		fix_rx_pkg::fix_class_e cls;
		fix_rx_pkg::seq_t       seq;
		logic                   chk_seq;
	} verdict_t;

	logic                   clk;
	logic                   rst;
	logic                   tag_valid, val_valid, som, eom, cs_ok;
	fix_rx_pkg::tag_t       tag;
	fix_rx_pkg::val_t       val;
	fix_rx_pkg::seq_t       exp_seq;
	logic                   result_valid;
	fix_rx_pkg::fix_err_e   res_err;
	fix_rx_pkg::fix_class_e res_cls;
	fix_rx_pkg::seq_t       res_seq;

	// message under construction and what the model knows about it
	fix_rx_pkg::tag_t       m_tag[$];
	fix_rx_pkg::val_t       m_val[$];
	fix_rx_pkg::fix_class_e m_cls;
	fix_rx_pkg::seq_t       m_seq;
	logic                   m_has_seq, m_has_snd, m_has_tgt, m_has_time, m_poss, m_gap, m_bad;
	verdict_t               exp_q[$];
	int                     cyc = 0;
	int                     errors = 0;
	int                     tests_ok = 0;
	int                     tests_bad = 0;

	tb_clk_gen u_clk (.clk_o(clk), .rst_o(rst));

	fix_rx_top u_dut (
		.clk(clk), .rst(rst),
		.tag_valid_i(tag_valid), .tag_i(tag), .val_valid_i(val_valid), .val_i(val),
		.start_of_message_i(som), .end_of_message_i(eom),
		.checksum_ok_i(cs_ok), .expected_seq_i(exp_seq),
		.result_valid_o(result_valid), .error_o(res_err),
		.msg_class_o(res_cls), .seq_num_o(res_seq)
	);

	function automatic void check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Fail at %0t: %s expected %0d got %0d", $time, name, want, got);
			errors++;
		end
	endfunction

	// outputs are sampled on the falling edge, away from the drive edge
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
			if (!result_valid) begin
				$display("at %0t result_valid_o missing 2 cycles after the deciding beat", $time);
				errors++;
			end else begin
				check_value("error_o", 32'(res_err), 32'(exp_q[0].err));
				check_value("msg_class_o", 32'(res_cls), 32'(exp_q[0].cls));
				if (exp_q[0].chk_seq)
					check_value("seq_num_o", 32'(res_seq), 32'(exp_q[0].seq));
			end
			void'(exp_q.pop_front());
		end else if (result_valid) begin
			$display("at %0t result_valid_o pulsed with no verdict due", $time);
			errors++;
		end
	end

	initial begin
		wait (cyc >= MAX_CYCLES);
		$display("run stopped after %0d cycles, tests did not finish", MAX_CYCLES);
		$display("Regression failed");
		$finish;
	end

	// right-justified ASCII value
	function automatic fix_rx_pkg::val_t chars(input string s);
		fix_rx_pkg::val_t v;
		v = '0;
		for (int i = 0; i < s.len(); i++)
			v = {v[55:0], s[i]};
		return v;
	endfunction

	function automatic fix_rx_pkg::val_t to_ascii(input int n);
		fix_rx_pkg::val_t v;
		int               k;
		v = '0;
		k = 0;
		do begin
			v[k*8 +: 8] = 8'h30 + 8'(n % 10);
			n = n / 10;
			k++;
		end while (n > 0);
		return v;
	endfunction

	function automatic void add_field(input fix_rx_pkg::tag_t t, input fix_rx_pkg::val_t v);
		m_tag.push_back(t);
		m_val.push_back(v);
		case (t)
			`FIX_TAG_SEQNUM:   m_has_seq = 1'b1;
			`FIX_TAG_SENDER:   m_has_snd = 1'b1;
			`FIX_TAG_TARGET:   m_has_tgt = 1'b1;
			`FIX_TAG_SENDTIME: m_has_time = 1'b1;
			`FIX_TAG_POSSDUP:  m_poss = (v == chars("Y"));
			`FIX_TAG_GAPFILL:  m_gap = (v == chars("Y"));
			default: ;
		endcase
	endfunction

	// keep selects tags 34, 49, 56 and 52, msb first
	function automatic void build_msg(input logic [7:0] mt, input fix_rx_pkg::fix_class_e cls,
			input int seq, input logic [3:0] keep);
		m_tag.delete();
		m_val.delete();
		{m_has_seq, m_has_snd, m_has_tgt, m_has_time, m_poss, m_gap, m_bad} = '0;
		m_seq = '0;
		m_cls = cls;
		add_field(`FIX_TAG_BEGIN, chars("FIX.4.4"));
		add_field(`FIX_TAG_BODYLEN, chars("128"));
		add_field(`FIX_TAG_MSGTYPE, {56'h0, mt});
		if (keep[3]) begin
			add_field(`FIX_TAG_SEQNUM, to_ascii(seq));
			m_seq = fix_rx_pkg::seq_t'(seq);
		end
		if (keep[2])
			add_field(`FIX_TAG_SENDER, chars("SNDR"));
		if (keep[1])
			add_field(`FIX_TAG_TARGET, chars("TRGT"));
		if (keep[0])
			add_field(`FIX_TAG_SENDTIME, chars("08:00:00"));
	endfunction

	// verdict rules: garbled, missing tag, low, high, none
	function automatic fix_rx_pkg::fix_err_e expected_error(input logic csum,
			input fix_rx_pkg::seq_t expect_seq);
		if (!csum || m_bad)
			return fix_rx_pkg::ERR_GARBLED;
		if (!(m_has_seq && m_has_snd && m_has_tgt && m_has_time))
			return fix_rx_pkg::ERR_TAG_MISSING;
		if (m_seq < expect_seq && !(m_poss || (m_cls == fix_rx_pkg::CLS_SEQ_RESET && !m_gap)))
			return fix_rx_pkg::ERR_SEQ_LOW;
		if (m_seq > expect_seq)
			return fix_rx_pkg::ERR_SEQ_HIGH;
		return fix_rx_pkg::ERR_NONE;
	endfunction

	function automatic fix_rx_pkg::fix_class_e expected_class();
		if (m_cls == fix_rx_pkg::CLS_SEQ_RESET && m_gap)
			return fix_rx_pkg::CLS_GAP_FILL;
		return m_cls;
	endfunction

	task automatic send_tag(input fix_rx_pkg::tag_t t, input logic first, input logic last);
		@(posedge clk);
		tag_valid <= 1'b1;
		val_valid <= 1'b0;
		tag <= t;
		som <= first;
		eom <= last;
	endtask

	task automatic send_val(input fix_rx_pkg::val_t v);
		@(posedge clk);
		tag_valid <= 1'b0;
		val_valid <= 1'b1;
		val <= v;
		som <= 1'b0;
		eom <= 1'b0;
	endtask

	// verdict is due 2 cycles after beat decide, or after the end beat when decide is -1
	task automatic drive_msg(input logic csum, input int expect_n, input int decide,
			input fix_rx_pkg::fix_err_e err, input fix_rx_pkg::fix_class_e cls,
			input logic chk_seq);
		verdict_t v;
		v.err = err;
		v.cls = cls;
		v.seq = (err == fix_rx_pkg::ERR_NONE || decide < 0) ? m_seq : '0;
		v.chk_seq = chk_seq;
		for (int i = 0; i < m_tag.size(); i++) begin
			send_tag(m_tag[i], i == 0, 1'b0);
			if (decide == 2 * i) begin
				v.due = cyc + 3;
				exp_q.push_back(v);
			end
			send_val(m_val[i]);
			if (decide == 2 * i + 1) begin
				v.due = cyc + 3;
				exp_q.push_back(v);
			end
		end
		send_tag(`FIX_TAG_CHECKSUM, 1'b0, 1'b1);
		cs_ok <= csum;
		exp_seq <= fix_rx_pkg::seq_t'(expect_n);
		if (decide < 0) begin
			v.due = cyc + 3;
			exp_q.push_back(v);
		end
	endtask

	task automatic send_msg(input logic csum, input int expect_n);
		drive_msg(csum, expect_n, -1, expected_error(csum, fix_rx_pkg::seq_t'(expect_n)),
			expected_class(), !m_bad);
	endtask

	task automatic report_test(input string name, input int e0);
		@(posedge clk);
		tag_valid <= 1'b0;
		val_valid <= 1'b0;
		som <= 1'b0;
		eom <= 1'b0;
		while (exp_q.size() > 0)
			@(negedge clk);
		if (errors == e0) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - e0);
		end
	endtask

	task automatic session_types();
		int e0;
		e0 = errors;
		build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 17, 4'hf);
		send_msg(1'b1, 17);
		build_msg(`FIX_MT_LOGON, fix_rx_pkg::CLS_LOGON, 1, 4'hf);
		send_msg(1'b1, 1);
		build_msg(`FIX_MT_LOGOUT, fix_rx_pkg::CLS_LOGOUT, 250, 4'hf);
		send_msg(1'b1, 250);
		build_msg(`FIX_MT_RESEND, fix_rx_pkg::CLS_RESEND, 3000, 4'hf);
		send_msg(1'b1, 3000);
		report_test("session types", e0);
	endtask

	task automatic header_errors();
		int                   e0;
		int                   beat;
		fix_rx_pkg::fix_err_e err;
		e0 = errors;
		for (int c = 0; c < 4; c++) begin
			build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 40, 4'hf);
			err = fix_rx_pkg::ERR_GARBLED;
			case (c)
				0: begin
					m_tag[0] = `FIX_TAG_SENDER;
					beat = 0;
				end
				1: begin
					m_val[0] = chars("FIX.4.5");
					err = fix_rx_pkg::ERR_BAD_VERSION;
					beat = 1;
				end
				// type tag where the body length tag belongs
				2: begin
					m_tag[1] = `FIX_TAG_MSGTYPE;
					m_val[1] = chars("0");
					beat = 2;
				end
				default: begin
					m_val[2] = chars("Z");
					err = fix_rx_pkg::ERR_BAD_MSG_TYPE;
					beat = 5;
				end
			endcase
			drive_msg(1'b1, 40, beat, err, fix_rx_pkg::CLS_NONE, 1'b1);
			build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 41, 4'hf);
			send_msg(1'b1, 41);
		end
		report_test("header errors", e0);
	endtask

	task automatic field_priority();
		int e0;
		e0 = errors;
		build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 20, 4'b1110);
		send_msg(1'b0, 20);
		send_msg(1'b1, 20);
		build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 20, 4'b0111);
		add_field(`FIX_TAG_SEQNUM, chars("12X4"));
		m_bad = 1'b1;
		send_msg(1'b1, 20);
		report_test("field priority", e0);
	endtask

	task automatic sequence_rules();
		int e0;
		e0 = errors;
		build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 5, 4'hf);
		send_msg(1'b1, 9);
		add_field(`FIX_TAG_POSSDUP, chars("Y"));
		send_msg(1'b1, 9);
		build_msg(`FIX_MT_HEARTBEAT, fix_rx_pkg::CLS_HEARTBEAT, 12, 4'hf);
		send_msg(1'b1, 9);
		build_msg(`FIX_MT_SEQRESET, fix_rx_pkg::CLS_SEQ_RESET, 3, 4'hf);
		send_msg(1'b1, 9);
		build_msg(`FIX_MT_SEQRESET, fix_rx_pkg::CLS_SEQ_RESET, 9, 4'hf);
		add_field(`FIX_TAG_GAPFILL, chars("Y"));
		send_msg(1'b1, 9);
		report_test("sequence rules", e0);
	endtask

	// back to back, so several verdicts are in flight
	task automatic random_orders();
		int         e0;
		int         expect_n;
		int         seq;
		logic [3:0] keep;
		e0 = errors;
		for (int n = 0; n < 30; n++) begin
			expect_n = $urandom_range(3, 99999990);
			seq = expect_n + $urandom_range(0, 6) - 3;
			keep = {$urandom_range(0, 15) != 0, $urandom_range(0, 7) != 0,
				$urandom_range(0, 7) != 0, $urandom_range(0, 7) != 0};
			build_msg(`FIX_MT_ORDER, fix_rx_pkg::CLS_BUSINESS, seq, keep);
			if ($urandom_range(0, 3) == 0)
				add_field(`FIX_TAG_POSSDUP, chars("Y"));
			send_msg($urandom_range(0, 7) != 0, expect_n);
		end
		report_test("random orders", e0);
	endtask

	initial begin
		void'($urandom(32'hd1f4_40ea));
		tag_valid <= 1'b0;
		val_valid <= 1'b0;
		som <= 1'b0;
		eom <= 1'b0;
		cs_ok <= 1'b0;
		tag <= '0;
		val <= '0;
		exp_seq <= '0;
		@(negedge rst);
		session_types();
		header_errors();
		field_priority();
		sequence_rules();
		random_orders();
		$display("tests passed %0d, failed %0d", tests_ok, tests_bad);
		if (tests_bad == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* fix_rx.f */
+incdir+verilog
verilog/fix_rx_pkg.sv
verilog/fix_header_checker.sv
verilog/fix_field_capture.sv
verilog/fix_msg_classifier.sv
verilog/fix_rx_top.sv
dv/tb_clk_gen.sv
dv/fix_rx_tb.sv

/* Makefile */
# Verilator build and run of the fix_rx testbench

VERILATOR ?= verilator
TOP       ?= fix_rx_tb
FILELIST  ?= fix_rx.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
